// ==== design/rv32_csr_pkg.sv ====
`default_nettype none

package rv32_csr_pkg;

    // --------------------
    // Machine CSR addresses
    // --------------------
    localparam logic [11:0] csr_misa      = 12'h301;
    localparam logic [11:0] csr_mscratch  = 12'h340;

    localparam logic [11:0] csr_mcycle    = 12'hB00;
    localparam logic [11:0] csr_minstret  = 12'hB02;
    localparam logic [11:0] csr_mcycleh   = 12'hB80;
    localparam logic [11:0] csr_minstreth = 12'hB82;

    // User counter shadows.
    localparam logic [11:0] csr_cycle     = 12'hC00;
    localparam logic [11:0] csr_time      = 12'hC01;
    localparam logic [11:0] csr_instret   = 12'hC02;
    localparam logic [11:0] csr_cycleh    = 12'hC80;
    localparam logic [11:0] csr_timeh     = 12'hC81;
    localparam logic [11:0] csr_instreth  = 12'hC82;

    localparam logic [11:0] csr_mvendorid = 12'hF11;
    localparam logic [11:0] csr_marchid   = 12'hF12;
    localparam logic [11:0] csr_mimpid    = 12'hF13;
    localparam logic [11:0] csr_mhartid   = 12'hF14;

    // Ranges that read as zero.
    localparam logic [11:0] csr_mhpmevent_base    = 12'h323;
    localparam int          csr_mhpmevent_count   = 29;
    localparam logic [11:0] csr_pmpcfg_base       = 12'h3A0;
    localparam int          csr_pmpcfg_count      = 4;
    localparam logic [11:0] csr_pmpaddr_base      = 12'h3B0;
    localparam int          csr_pmpaddr_count     = 16;
    localparam logic [11:0] csr_mhpmcounter_base  = 12'hB03;
    localparam logic [11:0] csr_mhpmcounterh_base = 12'hB83;
    localparam int          csr_mhpmcounter_count = 29;

    // --------------------
    // Encodings
    // --------------------
    localparam logic [31:0] misa_value    = 32'h4000_0100; // MXL=1, I only.
    localparam logic [6:0]  opcode_system = 7'b1110011;

    typedef enum logic [1:0] {
        op_rw = 2'b00,
        op_rs = 2'b01,
        op_rc = 2'b10
    } csr_write_op_e;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [11:0] addr;
        logic [4:0]  src;     // rs1 index or zimm.
        logic        imm_sel;
        logic [1:0]  op;      // Raw funct3[1:0].
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } csr_type_t;

    typedef union packed {
        i_type_t   i_type;
        csr_type_t csr_type;
    } rv32_instr_u;

    typedef struct packed {
        logic          valid;
        logic          read;
        logic          write;
        csr_write_op_e op;
        logic [11:0]   addr;
        logic [4:0]    rd;
        logic [31:0]   src_value;
    } csr_req_t;

    typedef struct packed {
        logic [63:0] cycle;
        logic [63:0] instret;
    } csr_counters_t;

endpackage

`default_nettype wire

// ==== design/rv32_csr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32_csr_decode import rv32_csr_pkg::*; (
    input  rv32_instr_u instr,
    input  logic        instr_valid,
    input  logic [31:0] rs1_value,
    output csr_req_t    req,
    output logic        bad_funct3
);

    logic          is_system;
    logic          funct3_ok;
    logic          valid;
    logic          rd_is_x0;
    logic          src_is_zero;
    csr_write_op_e op;
    logic [31:0]   src_value;

    // --------------------
    // Legality from the i_type view
    // --------------------
    assign is_system = instr.i_type.opcode == opcode_system;

    // 000 and 100 are not CSR instructions.
    assign funct3_ok = instr.i_type.funct3[1:0] != 2'b00;

    assign valid      = instr_valid && is_system;
    assign bad_funct3 = valid && !funct3_ok;

    // --------------------
    // Request from the csr_type view
    // --------------------
    always_comb begin
        case (instr.csr_type.op)
            2'b01:   op = op_rw;
            2'b10:   op = op_rs;
            2'b11:   op = op_rc;
            default: op = op_rw; // Flagged by bad_funct3.
        endcase
    end

    assign rd_is_x0    = instr.csr_type.rd == 5'd0;
    assign src_is_zero = instr.csr_type.src == 5'd0;

    always_comb begin
        if (instr.csr_type.imm_sel) begin
            src_value = {27'b0, instr.csr_type.src}; // Zero-extended zimm.
        end else begin
            src_value = rs1_value;
        end
    end

    always_comb begin
        req.valid     = valid;
        // A plain write to x0 does not read the CSR.
        req.read      = valid && (!rd_is_x0 || op != op_rw);
        // Set or clear with a zero source leaves the CSR alone.
        req.write     = valid && (op == op_rw || !src_is_zero);
        req.op        = op;
        req.addr      = instr.csr_type.addr;
        req.rd        = instr.csr_type.rd;
        req.src_value = src_value;
    end

endmodule

`default_nettype wire

// ==== design/rv32_csr_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32_csr_counters import rv32_csr_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          instr_retired,
    output csr_counters_t counters
);

    logic [63:0] cycle;
    logic [63:0] instret;

    // Free running even under stall.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle <= 64'd0;
        end else begin
            cycle <= cycle + 64'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instret <= 64'd0;
        end else if (instr_retired) begin
            instret <= instret + 64'd1;
        end
    end

    assign counters.cycle   = cycle;
    assign counters.instret = instret;

    // --------------------
    // Checks
    // --------------------
    cycle_step_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> counters.cycle == $past(counters.cycle) + 64'd1
    ) else $error("cycle counter did not advance by one");

endmodule

`default_nettype wire

// ==== design/rv32_csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32_csr_file import rv32_csr_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          stall,
    input  csr_req_t      req,
    input  logic          bad_funct3,
    input  csr_counters_t counters,
    output logic [31:0]   rd_value,
    output logic          rd_write,
    output logic          illegal
);

    logic [31:0] mscratch;
    logic [31:0] old_value;
    logic [31:0] new_value;
    logic        known;
    logic        ro_write;
    logic        req_illegal;
    logic        accept;

    // --------------------
    // Read multiplexer
    // --------------------
    always_comb begin
        known     = 1'b1;
        old_value = 32'd0;
        case (req.addr) inside
            csr_misa:                          old_value = misa_value;
            csr_mscratch:                      old_value = mscratch;
            csr_mcycle, csr_cycle, csr_time:   old_value = counters.cycle[31:0];
            csr_mcycleh, csr_cycleh, csr_timeh: old_value = counters.cycle[63:32];
            csr_minstret, csr_instret:         old_value = counters.instret[31:0];
            csr_minstreth, csr_instreth:       old_value = counters.instret[63:32];
            csr_mvendorid, csr_marchid,
            csr_mimpid, csr_mhartid:           old_value = 32'd0;
            [csr_mhpmevent_base :
             csr_mhpmevent_base + 12'(csr_mhpmevent_count - 1)]:
                old_value = 32'd0;
            [csr_pmpcfg_base :
             csr_pmpcfg_base + 12'(csr_pmpcfg_count - 1)]:
                old_value = 32'd0;
            [csr_pmpaddr_base :
             csr_pmpaddr_base + 12'(csr_pmpaddr_count - 1)]:
                old_value = 32'd0;
            [csr_mhpmcounter_base :
             csr_mhpmcounter_base + 12'(csr_mhpmcounter_count - 1)]:
                old_value = 32'd0;
            [csr_mhpmcounterh_base :
             csr_mhpmcounterh_base + 12'(csr_mhpmcounter_count - 1)]:
                old_value = 32'd0;
            default: begin
                known     = 1'b0; // Unimplemented address.
                old_value = 32'd0;
            end
        endcase
    end

    // --------------------
    // Write value and legality
    // --------------------
    always_comb begin
        case (req.op)
            op_rw:   new_value = req.src_value;
            op_rs:   new_value = old_value | req.src_value;
            op_rc:   new_value = old_value & ~req.src_value;
            default: new_value = req.src_value;
        endcase
    end

    assign ro_write    = req.write && req.addr[11:10] == 2'b11;
    assign req_illegal = bad_funct3 || !known || ro_write;
    assign accept      = req.valid && !stall;

    // Counter writes are legal but dropped.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mscratch <= 32'd0;
        end else if (accept && req.write && !req_illegal && req.addr == csr_mscratch) begin
            mscratch <= new_value;
        end
    end

    // --------------------
    // Result register
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_write <= 1'b0;
            illegal  <= 1'b0;
        end else begin
            rd_write <= accept && req.read && !req_illegal;
            illegal  <= accept && req_illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rd_value <= old_value; // Value before this edge's write.
        end
    end

    strobe_excl_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(rd_write && illegal)
    ) else $error("rd_write and illegal raised together");

    op_code_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        req.valid |-> req.op inside {op_rw, op_rs, op_rc}
    ) else $error("valid request carries op code 11");

endmodule

`default_nettype wire

// ==== design/rv32_csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32_csr_unit import rv32_csr_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] instr,
    input  logic        instr_valid,
    input  logic [31:0] rs1_value,
    input  logic        stall,
    input  logic        instr_retired,
    output logic [31:0] rd_value,
    output logic        rd_write,
    output logic        illegal
);

    csr_req_t      req;
    logic          bad_funct3;
    csr_counters_t counters;

    // --------------------
    // Decode
    // --------------------
    rv32_csr_decode u_decode (
        .instr       (instr),
        .instr_valid (instr_valid),
        .rs1_value   (rs1_value),
        .req         (req),
        .bad_funct3  (bad_funct3)
    );

    rv32_csr_counters u_counters (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_retired (instr_retired),
        .counters      (counters)
    );

    // Results registered one cycle after the request.
    rv32_csr_file u_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .req        (req),
        .bad_funct3 (bad_funct3),
        .counters   (counters),
        .rd_value   (rd_value),
        .rd_write   (rd_write),
        .illegal    (illegal)
    );

endmodule

`default_nettype wire

// ==== tb/rv32_csr_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32_csr_tb import rv32_csr_pkg::*; ();

    localparam int num_cycles     = 4000;
    localparam int timeout_cycles = 6000;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr;
    logic        instr_valid;
    logic [31:0] rs1_value;
    logic        stall;
    logic        instr_retired;
    logic [31:0] rd_value;
    logic        rd_write;
    logic        illegal;

    integer      seed;
    int          errors;
    int          checks;
    logic        exp_rd_write;
    logic        exp_illegal;
    logic [31:0] exp_rd_value;
    logic [11:0] last_addr;
    logic [31:0] m_mscratch;
    logic [63:0] m_cycle;
    logic [63:0] m_instret;

    rv32_csr_unit u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr         (instr),
        .instr_valid   (instr_valid),
        .rs1_value     (rs1_value),
        .stall         (stall),
        .instr_retired (instr_retired),
        .rd_value      (rd_value),
        .rd_write      (rd_write),
        .illegal       (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // --------------------
    // Reference model
    // --------------------
    function automatic int urand(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    function automatic logic in_range(input logic [11:0] addr, input logic [11:0] base,
                                      input int count);
        return int'(addr) >= int'(base) && int'(addr) < int'(base) + count;
    endfunction

    function automatic logic csr_known(input logic [11:0] addr);
        logic hit;
        hit = addr inside {csr_misa, csr_mscratch, csr_mcycle, csr_minstret, csr_mcycleh,
                           csr_minstreth, csr_cycle, csr_time, csr_instret, csr_cycleh,
                           csr_timeh, csr_instreth, csr_mvendorid, csr_marchid,
                           csr_mimpid, csr_mhartid};
        hit = hit || in_range(addr, csr_mhpmevent_base, csr_mhpmevent_count);
        hit = hit || in_range(addr, csr_pmpcfg_base, csr_pmpcfg_count);
        hit = hit || in_range(addr, csr_pmpaddr_base, csr_pmpaddr_count);
        hit = hit || in_range(addr, csr_mhpmcounter_base, csr_mhpmcounter_count);
        hit = hit || in_range(addr, csr_mhpmcounterh_base, csr_mhpmcounter_count);
        return hit;
    endfunction

    // Time aliases cycle.
    function automatic logic [31:0] csr_value(input logic [11:0] addr);
        case (addr)
            csr_misa:                           return misa_value;
            csr_mscratch:                       return m_mscratch;
            csr_mcycle, csr_cycle, csr_time:    return m_cycle[31:0];
            csr_mcycleh, csr_cycleh, csr_timeh: return m_cycle[63:32];
            csr_minstret, csr_instret:          return m_instret[31:0];
            csr_minstreth, csr_instreth:        return m_instret[63:32];
            default:                            return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] csr_word(input logic [11:0] addr, input logic [4:0] src,
                                             input logic [2:0] f3, input logic [4:0] rd);
        return {addr, src, f3, rd, opcode_system};
    endfunction

    function automatic logic [11:0] pick_addr();
        int          sel;
        logic [11:0] addr;
        sel = urand(100);
        if (sel < 25) begin
            addr = csr_mscratch;
        end else if (sel < 60) begin
            case (urand(15))
                0:       addr = csr_misa;
                1:       addr = csr_mcycle;
                2:       addr = csr_mcycleh;
                3:       addr = csr_minstret;
                4:       addr = csr_minstreth;
                5:       addr = csr_cycle;
                6:       addr = csr_time;
                7:       addr = csr_instret;
                8:       addr = csr_cycleh;
                9:       addr = csr_timeh;
                10:      addr = csr_instreth;
                11:      addr = csr_mvendorid;
                12:      addr = csr_marchid;
                13:      addr = csr_mimpid;
                default: addr = csr_mhartid;
            endcase
        end else if (sel < 75) begin
            case (urand(5))
                0:       addr = csr_mhpmevent_base + 12'(urand(csr_mhpmevent_count));
                1:       addr = csr_pmpcfg_base + 12'(urand(csr_pmpcfg_count));
                2:       addr = csr_pmpaddr_base + 12'(urand(csr_pmpaddr_count));
                3:       addr = csr_mhpmcounter_base + 12'(urand(csr_mhpmcounter_count));
                default: addr = csr_mhpmcounterh_base + 12'(urand(csr_mhpmcounter_count));
            endcase
        end else if (sel < 90) begin
            addr = 12'(urand(4096)); // Mostly unknown.
        end else begin
            addr = {2'b11, 10'(urand(1024))}; // Read-only space.
        end
        return addr;
    endfunction

    task automatic check_outputs();
        checks++;
        if (rd_write !== exp_rd_write) begin
            errors++;
            $display("Fail %0t: addr %h rd_write %b, expected %b",
                     $time, last_addr, rd_write, exp_rd_write);
        end
        if (illegal !== exp_illegal) begin
            errors++;
            $display("Fail %0t: addr %h illegal %b, expected %b",
                     $time, last_addr, illegal, exp_illegal);
        end
        if (exp_rd_write && rd_value !== exp_rd_value) begin
            errors++;
            $display("Fail %0t: addr %h rd_value %h, expected %h",
                     $time, last_addr, rd_value, exp_rd_value);
        end
    endtask

    // Runs from one falling edge to the next.
    task automatic run_cycle(input logic valid, input logic [31:0] word,
                             input logic [31:0] rs1, input logic stl, input logic ret);
        logic        accept;
        logic        reads;
        logic        writes;
        logic        ill;
        logic [31:0] opnd;
        logic [31:0] old;
        instr         = word;
        instr_valid   = valid;
        rs1_value     = rs1;
        stall         = stl;
        instr_retired = ret;
        last_addr     = word[31:20];
        reads  = word[11:7] != 5'd0 || word[13:12] != 2'b01;
        writes = word[13:12] == 2'b01 || word[19:15] != 5'd0;
        ill    = word[13:12] == 2'b00 || !csr_known(word[31:20]);
        ill    = ill || (writes && word[31:30] == 2'b11);
        accept = valid && word[6:0] == opcode_system && !stl;
        old    = csr_value(word[31:20]);
        opnd   = word[14] ? {27'd0, word[19:15]} : rs1;
        exp_rd_write = accept && reads && !ill;
        exp_illegal  = accept && ill;
        exp_rd_value = old;
        if (accept && writes && !ill && word[31:20] == csr_mscratch) begin
            case (word[13:12])
                2'b01:   m_mscratch = opnd;
                2'b10:   m_mscratch = old | opnd;
                default: m_mscratch = old & ~opnd;
            endcase
        end
        m_cycle = m_cycle + 64'd1;
        if (ret) begin
            m_instret = m_instret + 64'd1;
        end
        @(negedge clk);
        check_outputs();
    endtask

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        logic [31:0] word;
        logic [31:0] rs1;
        logic        valid_in;
        logic        stall_in;
        logic        held;
        seed          = 32'hfa69_9e79;
        errors        = 0;
        checks        = 0;
        rst_n         = 1'b0;
        instr         = 32'd0;
        instr_valid   = 1'b0;
        rs1_value     = 32'd0;
        stall         = 1'b0;
        instr_retired = 1'b0;
        exp_rd_write  = 1'b0;
        exp_illegal   = 1'b0;
        exp_rd_value  = 32'd0;
        last_addr     = 12'd0;
        m_mscratch    = 32'd0;
        m_cycle       = 64'd0;
        m_instret     = 64'd0;
        word          = 32'd0;
        rs1           = 32'd0;
        valid_in      = 1'b0;
        held          = 1'b0;
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            if (rd_write !== 1'b0 || illegal !== 1'b0) begin
                errors++;
                $display("Fail %0t: strobe raised while reset is held, rd_write %b illegal %b",
                         $time, rd_write, illegal);
            end
        end
        rst_n = 1'b1;

        // Directed mscratch sequence.
        run_cycle(1'b1, csr_word(csr_mscratch, 5'd0, 3'b010, 5'd5), 32'h0, 1'b0, 1'b0);
        run_cycle(1'b1, csr_word(csr_misa, 5'd0, 3'b010, 5'd5), 32'h0, 1'b0, 1'b1);
        run_cycle(1'b1, csr_word(csr_mscratch, 5'd3, 3'b001, 5'd5), 32'ha5a5_0f0f, 1'b0, 1'b0);
        run_cycle(1'b1, csr_word(csr_mscratch, 5'd3, 3'b010, 5'd6), 32'h0000_f0f0, 1'b0, 1'b0);
        run_cycle(1'b1, csr_word(csr_mscratch, 5'h0f, 3'b111, 5'd7), 32'hffff_ffff, 1'b0, 1'b0);
        run_cycle(1'b1, csr_word(csr_mscratch, 5'h10, 3'b110, 5'd8), 32'h0, 1'b0, 1'b1);
        run_cycle(1'b1, csr_word(csr_mscratch, 5'd0, 3'b011, 5'd8), 32'hffff_ffff, 1'b0, 1'b0);
        run_cycle(1'b1, csr_word(csr_mscratch, 5'd3, 3'b001, 5'd0), 32'h1234_5678, 1'b0, 1'b0);
        run_cycle(1'b1, csr_word(csr_mscratch, 5'd3, 3'b001, 5'd5), 32'hffff_ffff, 1'b1, 1'b1);
        run_cycle(1'b1, csr_word(csr_mscratch, 5'd0, 3'b010, 5'd9), 32'h0, 1'b0, 1'b0);
        run_cycle(1'b1, csr_word(csr_mvendorid, 5'd0, 3'b010, 5'd5), 32'h0, 1'b0, 1'b0);
        run_cycle(1'b1, csr_word(csr_cycle, 5'd3, 3'b001, 5'd5), 32'h1, 1'b0, 1'b0);
        run_cycle(1'b1, csr_word(12'h7c0, 5'd0, 3'b010, 5'd5), 32'h0, 1'b0, 1'b0);
        run_cycle(1'b1, csr_word(csr_mscratch, 5'd3, 3'b100, 5'd5), 32'h0, 1'b0, 1'b0);
        run_cycle(1'b1, csr_word(csr_instret, 5'd0, 3'b010, 5'd5), 32'h0, 1'b0, 1'b0);

        // Random traffic held while stalled.
        for (int n = 0; n < num_cycles; n++) begin
            if (!held) begin
                word = csr_word(pick_addr(),
                                urand(4) == 0 ? 5'd0 : 5'(urand(32)),
                                3'(urand(8)),
                                urand(4) == 0 ? 5'd0 : 5'(urand(32)));
                if (urand(20) == 0) begin
                    word[6:0] = 7'b0010011; // Not a SYSTEM op.
                end
                valid_in = urand(10) != 0;
                rs1      = $random(seed);
            end
            stall_in = urand(5) == 0;
            run_cycle(valid_in, word, rs1, stall_in, urand(2) == 0);
            held = valid_in && stall_in;
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        for (int t = 0; t < timeout_cycles; t++) begin
            @(posedge clk);
        end
        $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
design/rv32_csr_pkg.sv
design/rv32_csr_decode.sv
design/rv32_csr_counters.sv
design/rv32_csr_file.sv
design/rv32_csr_unit.sv
tb/rv32_csr_tb.sv

// ==== Bender.yml ====
package:
  name: rv32_csr

sources:
  # Package first, then the RTL in dependency order.
  - files:
      - design/rv32_csr_pkg.sv
      - design/rv32_csr_decode.sv
      - design/rv32_csr_counters.sv
      - design/rv32_csr_file.sv
      - design/rv32_csr_unit.sv

  # Testbench, top module rv32_csr_tb.
  - target: simulation
    files:
      - tb/rv32_csr_tb.sv
